/* Makefile */
TOP = dbg_bridge_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir

/* rtl/axil_scratch_mem.sv */
// AXI-lite scratch memory
// Word array behind a fixed address window with byte strobes.
// Addresses outside the window never see a ready

`timescale 1ns/1ps

module axil_scratch_mem #(
    parameter int          MEM_WORDS = 64,
    parameter logic [31:0] MEM_BASE  = 32'h0000_1000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dbg_bus_pkg::axil_m2s_t m2s_i,
    output dbg_bus_pkg::axil_s2m_t s2m_o
);

    import dbg_bus_pkg::*;

    localparam int          IDX_W   = $clog2(MEM_WORDS);
    localparam logic [31:0] MEM_END = MEM_BASE + 32'(4 * MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];

    logic [31:0]      aw_off, ar_off;
    logic             aw_hit, ar_hit;
    logic             aw_held_q;
    logic [IDX_W-1:0] aw_idx_q;
    logic             bvalid_q, rvalid_q;
    logic [31:0]      rdata_q;
    logic             aw_fire, w_fire, ar_fire;

    // ============================================================
    // Window decode
    // ============================================================
    assign aw_off = m2s_i.awaddr - MEM_BASE;
    assign ar_off = m2s_i.araddr - MEM_BASE;
    assign aw_hit = (m2s_i.awaddr >= MEM_BASE) && (m2s_i.awaddr < MEM_END);
    assign ar_hit = (m2s_i.araddr >= MEM_BASE) && (m2s_i.araddr < MEM_END);

    // Ready in the same cycle as valid, one transfer at a time
    assign s2m_o.awready = m2s_i.awvalid && aw_hit && !aw_held_q && !bvalid_q;
    assign s2m_o.wready  = m2s_i.wvalid && aw_held_q;
    assign s2m_o.arready = m2s_i.arvalid && ar_hit && !rvalid_q;

    assign aw_fire = m2s_i.awvalid && s2m_o.awready;
    assign w_fire  = m2s_i.wvalid && s2m_o.wready;
    assign ar_fire = m2s_i.arvalid && s2m_o.arready;

    assign s2m_o.bvalid = bvalid_q;
    assign s2m_o.bresp  = RESP_OKAY;
    assign s2m_o.rvalid = rvalid_q;
    assign s2m_o.rdata  = rdata_q;
    assign s2m_o.rresp  = RESP_OKAY;

    // ============================================================
    // Storage and response registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            aw_held_q <= 1'b0;
            aw_idx_q  <= '0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            rdata_q   <= '0;
        end else begin
            if (aw_fire) begin
                aw_held_q <= 1'b1;
                aw_idx_q  <= aw_off[IDX_W+1:2];
            end
            if (w_fire) begin
                for (int b = 0; b < 4; b++) begin
                    if (m2s_i.wstrb[b]) begin
                        mem[aw_idx_q][8*b +: 8] <= m2s_i.wdata[8*b +: 8];
                    end
                end
                aw_held_q <= 1'b0;
                bvalid_q  <= 1'b1;
            end else if (bvalid_q && m2s_i.bready) begin
                bvalid_q <= 1'b0;
            end
            // Low address bits are ignored on reads
            if (ar_fire) begin
                rdata_q  <= mem[ar_off[IDX_W+1:2]];
                rvalid_q <= 1'b1;
            end else if (rvalid_q && m2s_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

endmodule

/* rtl/dbg_bridge_fsm.sv */
// Debug bridge state machine
// Accepts one debug request at a time, walks the AXI-lite channels
// in order and grants the requester on the B or R handshake.
// A timer expiry abandons the transfer and grants with an error

`timescale 1ns/1ps

module dbg_bridge_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_i,
    input  logic                   we_i,
    input  logic                   be_any_i,
    input  dbg_bus_pkg::axil_s2m_t s2m_i,
    input  logic                   expired_i,
    output logic                   capture_o,
    output logic                   run_o,
    output dbg_bus_pkg::axil_m2s_t m2s_ctrl_o,
    output logic                   gnt_o,
    output logic                   r_valid_o,
    output logic                   err_o,
    output logic                   rdata_take_o
);

    import dbg_bus_pkg::*;

    bridge_state_t state, next_state;

    // Write with no byte enabled, granted from idle on the next cycle
    logic noop_q, noop_next;

    // ============================================================
    // State registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= BR_IDLE;
            noop_q <= 1'b0;
        end else begin
            state  <= next_state;
            noop_q <= noop_next;
        end
    end

    // Timer runs whenever a bus transfer is in flight
    assign run_o = (state != BR_IDLE);

    // ============================================================
    // Next state, channel controls and grant
    // ============================================================
    always_comb begin
        next_state   = state;
        noop_next    = 1'b0;
        capture_o    = 1'b0;
        gnt_o        = 1'b0;
        r_valid_o    = 1'b0;
        err_o        = 1'b0;
        rdata_take_o = 1'b0;
        // Address and data fields come from the request latch
        m2s_ctrl_o   = '0;

        case (state)
            BR_IDLE: begin
                if (noop_q) begin
                    // Old request still on the port, do not accept it again
                    gnt_o = 1'b1;
                end else if (req_i) begin
                    capture_o = 1'b1;
                    if (we_i && !be_any_i) begin
                        noop_next = 1'b1;
                    end else if (we_i) begin
                        next_state = BR_WRITE_ADDR;
                    end else begin
                        next_state = BR_READ_ADDR;
                    end
                end
            end

            BR_WRITE_ADDR: begin
                m2s_ctrl_o.awvalid = !expired_i;
                if (s2m_i.awready && !expired_i) begin
                    next_state = BR_WRITE_DATA;
                end
            end

            BR_WRITE_DATA: begin
                m2s_ctrl_o.wvalid = !expired_i;
                if (s2m_i.wready && !expired_i) begin
                    next_state = BR_WRITE_RESP;
                end
            end

            BR_WRITE_RESP: begin
                m2s_ctrl_o.bready = 1'b1;
                if (s2m_i.bvalid) begin
                    gnt_o      = 1'b1;
                    err_o      = (s2m_i.bresp != RESP_OKAY);
                    next_state = BR_IDLE;
                end
            end

            BR_READ_ADDR: begin
                m2s_ctrl_o.arvalid = !expired_i;
                if (s2m_i.arready && !expired_i) begin
                    next_state = BR_READ_DATA;
                end
            end

            BR_READ_DATA: begin
                m2s_ctrl_o.rready = 1'b1;
                if (s2m_i.rvalid) begin
                    gnt_o        = 1'b1;
                    r_valid_o    = 1'b1;
                    rdata_take_o = 1'b1;
                    err_o        = (s2m_i.rresp != RESP_OKAY);
                    next_state   = BR_IDLE;
                end
            end

            default: begin
                next_state = BR_IDLE;
            end
        endcase

        // Target never answered, give up and report an error
        if (run_o && expired_i && !gnt_o) begin
            gnt_o        = 1'b1;
            err_o        = 1'b1;
            r_valid_o    = (state == BR_READ_ADDR) || (state == BR_READ_DATA);
            rdata_take_o = 1'b1;
            m2s_ctrl_o   = '0;
            next_state   = BR_IDLE;
        end
    end

endmodule

/* rtl/dbg_bridge_top.sv */
// Debug bridge top level
// Connects the bridge FSM, request latch and response timer to the
// AXI-lite scratch memory and sets their parameters

`timescale 1ns/1ps

module dbg_bridge_top #(
    parameter int          TIMEOUT_CYCLES = 32,
    parameter int          MEM_WORDS      = 64,
    parameter logic [31:0] MEM_BASE       = 32'h0000_1000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_i,
    input  dbg_bus_pkg::dbg_req_t dbg_req_i,
    output logic                  gnt_o,
    output logic                  r_valid_o,
    output logic                  err_o,
    output logic [31:0]           r_rdata_o
);

    import dbg_bus_pkg::*;

    axil_m2s_t m2s_ctrl, m2s_data, m2s;
    axil_s2m_t s2m;
    logic      capture, run, expired, be_any, rdata_take;

    // Controls from the FSM, payload from the latch
    always_comb begin
        m2s         = m2s_data;
        m2s.awvalid = m2s_ctrl.awvalid;
        m2s.wvalid  = m2s_ctrl.wvalid;
        m2s.bready  = m2s_ctrl.bready;
        m2s.arvalid = m2s_ctrl.arvalid;
        m2s.rready  = m2s_ctrl.rready;
    end

    dbg_bridge_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .we_i         (dbg_req_i.we),
        .be_any_i     (be_any),
        .s2m_i        (s2m),
        .expired_i    (expired),
        .capture_o    (capture),
        .run_o        (run),
        .m2s_ctrl_o   (m2s_ctrl),
        .gnt_o        (gnt_o),
        .r_valid_o    (r_valid_o),
        .err_o        (err_o),
        .rdata_take_o (rdata_take)
    );

    resp_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .run_i     (run),
        .expired_o (expired)
    );

    dbg_req_latch u_latch (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture_i    (capture),
        .req_i        (dbg_req_i),
        .rdata_take_i (rdata_take),
        .s2m_i        (s2m),
        .m2s_data_o   (m2s_data),
        .be_any_o     (be_any),
        .rdata_o      (r_rdata_o)
    );

    axil_scratch_mem #(
        .MEM_WORDS (MEM_WORDS),
        .MEM_BASE  (MEM_BASE)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .m2s_i (m2s),
        .s2m_o (s2m)
    );

endmodule

/* rtl/dbg_bus_pkg.sv */
// Debug bridge shared types
// Request fields from the debug module, the AXI-lite channel
// structs for both directions, the bridge states and response codes

package dbg_bus_pkg;

    // Word request as presented by the debug module
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [31:0] wdata;
        logic [3:0]  be;
    } dbg_req_t;

    // AXI-lite response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Master to target
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_m2s_t;

    // Target to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_t  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_t  rresp;
    } axil_s2m_t;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_WRITE_ADDR,
        BR_WRITE_DATA,
        BR_WRITE_RESP,
        BR_READ_ADDR,
        BR_READ_DATA
    } bridge_state_t;

endpackage

/* rtl/dbg_req_latch.sv */
// Debug request latch
// Holds the accepted request for the AXI-lite address, data and
// strobe fields, and keeps the last read data for the requester

`timescale 1ns/1ps

module dbg_req_latch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   capture_i,
    input  dbg_bus_pkg::dbg_req_t  req_i,
    input  logic                   rdata_take_i,
    input  dbg_bus_pkg::axil_s2m_t s2m_i,
    output dbg_bus_pkg::axil_m2s_t m2s_data_o,
    output logic                   be_any_o,
    output logic [31:0]            rdata_o
);

    import dbg_bus_pkg::*;

    dbg_req_t    req_q;
    logic [31:0] rdata_q;
    logic [31:0] rdata_new;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q   <= '0;
            rdata_q <= '0;
        end else begin
            if (capture_i) begin
                req_q <= req_i;
            end
            if (rdata_take_i) begin
                rdata_q <= rdata_new;
            end
        end
    end

    // A take without rvalid is a timeout grant, so the data reads as zero
    assign rdata_new = s2m_i.rvalid ? s2m_i.rdata : 32'h0;

    // Bypass so the data is on the port in the grant cycle
    assign rdata_o = rdata_take_i ? rdata_new : rdata_q;

    // Sampled by the FSM in the accept cycle, before the copy is held
    assign be_any_o = |req_i.be;

    always_comb begin
        m2s_data_o        = '0;
        m2s_data_o.awaddr = {req_q.addr[31:2], 2'b00};
        m2s_data_o.araddr = req_q.addr;
        m2s_data_o.wdata  = req_q.wdata;
        m2s_data_o.wstrb  = req_q.be;
    end

endmodule

/* rtl/resp_timer.sv */
// Response timer
// Counts cycles while a transfer is running and flags a target
// that has not answered within TIMEOUT_CYCLES

`timescale 1ns/1ps

module resp_timer #(
    parameter int TIMEOUT_CYCLES = 32
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(TIMEOUT_CYCLES);

    logic [CNT_W-1:0] count_q;

    // Clears between transfers, saturates at the limit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0;
        end else if (count_q != CNT_MAX) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign expired_o = (count_q == CNT_MAX);

endmodule

/* sim.f */
rtl/dbg_bus_pkg.sv
rtl/resp_timer.sv
rtl/dbg_req_latch.sv
rtl/axil_scratch_mem.sv
rtl/dbg_bridge_fsm.sv
rtl/dbg_bridge_top.sv
test/tb_clkgen.sv
test/dbg_bridge_checker.sv
test/dbg_bridge_assert.sv
test/dbg_bridge_tb.sv

/* test/dbg_bridge_assert.sv */
// Handshake assertions for the debug bridge FSM
// Bound into dbg_bridge_fsm, checks valid hold, grant width,
// reset state and one grant per accepted request

`timescale 1ns/1ps

module dbg_bridge_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   capture_i,
    input logic                   gnt_i,
    input logic                   expired_i,
    input dbg_bus_pkg::axil_m2s_t m2s_i,
    input dbg_bus_pkg::axil_s2m_t s2m_i
);

    // Set by an accept, cleared by its grant
    logic open_q;
    int   fail_count = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            open_q <= 1'b0;
        end else if (capture_i) begin
            open_q <= 1'b1;
        end else if (gnt_i) begin
            open_q <= 1'b0;
        end
    end

    // ============================================================
    // Channel valids wait for ready or a timeout
    // ============================================================
    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        m2s_i.awvalid && !s2m_i.awready |=> m2s_i.awvalid || expired_i)
        else begin fail_count++; $error("awvalid dropped before its handshake"); end

    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        m2s_i.arvalid && !s2m_i.arready |=> m2s_i.arvalid || expired_i)
        else begin fail_count++; $error("arvalid dropped before its handshake"); end

    gnt_single: assert property (@(posedge clk) disable iff (!rst_n)
        gnt_i |=> !gnt_i)
        else begin fail_count++; $error("gnt_o held longer than one cycle"); end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !(m2s_i.awvalid || m2s_i.wvalid || m2s_i.arvalid) && !gnt_i)
        else begin fail_count++; $error("valid or grant active after reset"); end

    gnt_matched: assert property (@(posedge clk) disable iff (!rst_n)
        gnt_i |-> open_q)
        else begin fail_count++; $error("grant without an accepted request"); end

    accept_free: assert property (@(posedge clk) disable iff (!rst_n)
        capture_i |-> !open_q)
        else begin fail_count++; $error("request accepted while one is open"); end

endmodule

bind dbg_bridge_fsm dbg_bridge_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .capture_i (capture_o),
    .gnt_i     (gnt_o),
    .expired_i (expired_i),
    .m2s_i     (m2s_ctrl_o),
    .s2m_i     (s2m_i)
);

/* test/dbg_bridge_checker.sv */
// Debug bridge response checker
// Holds the expected result of every request in issue order and
// compares each grant with the head entry on the falling edge

`timescale 1ns/1ps

module dbg_bridge_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        gnt_i,
    input  logic        r_valid_i,
    input  logic        err_i,
    input  logic [31:0] rdata_i,
    output int          error_count_o,
    output int          pending_o
);

    typedef struct packed {
        logic        is_read;
        logic [31:0] rdata;
        logic        err;
    } expect_t;

    expect_t exp_q[$];
    string   name_q[$];
    int      errors  = 0;
    int      pending = 0;

    assign error_count_o = errors;
    assign pending_o     = pending;

    // Called by the driver when it presents a request
    task automatic push_expected(input string name, input logic is_read,
                                 input logic [31:0] rdata, input logic err);
        expect_t e;
        e.is_read = is_read;
        e.rdata   = rdata;
        e.err     = err;
        exp_q.push_back(e);
        name_q.push_back(name);
        pending++;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %08h actual %08h", name, what, expected, actual);
            errors++;
        end
    endtask

    // ============================================================
    // Grant monitor
    // ============================================================
    always @(negedge clk) begin
        expect_t cur;
        string   name;
        if (rst_n && gnt_i) begin
            if (exp_q.size() == 0) begin
                $display("Grant at %0t ns arrived with no request pending", $time);
                errors++;
            end else begin
                cur  = exp_q.pop_front();
                name = name_q.pop_front();
                pending--;
                check_value(name, "err_o", 32'(cur.err), 32'(err_i));
                check_value(name, "r_valid_o", 32'(cur.is_read), 32'(r_valid_i));
                // Read grants carry data and timeout grants carry zero
                if (cur.is_read || cur.err) begin
                    check_value(name, "r_rdata_o", cur.rdata, rdata_i);
                end
            end
        end
    end

endmodule

/* test/dbg_bridge_tb.sv */
// Debug bridge testbench
// Reads requests and expected results from the stimulus file, drives
// them on the falling edge and waits for each grant under a watchdog

`timescale 1ns/1ps

module dbg_bridge_tb;

    import dbg_bus_pkg::*;

    localparam int          TIMEOUT_CYCLES = 32;
    localparam int          MEM_WORDS      = 64;
    localparam logic [31:0] MEM_BASE       = 32'h0000_1000;
    localparam int          RESET_CYCLES   = 16;

    typedef struct packed {
        logic [8*16-1:0] name;
        logic            is_write;
        logic [31:0]     addr;
        logic [31:0]     wdata;
        logic [3:0]      be;
        logic [7:0]      gap;
        logic [31:0]     exp_rdata;
        logic            exp_err;
    } stim_t;

    logic        clk, rst_n;
    logic        req, gnt, r_valid, err;
    logic [31:0] rdata;
    dbg_req_t    dbg_req;
    stim_t       stim_q[$];
    bit          loaded  = 1'b0;
    bit          load_ok = 1'b0;
    int          watchdog_cycles;
    int          check_errors, pending, total_errors;

    tb_clkgen #(.PERIOD_NS(4), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dbg_bridge_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .MEM_WORDS      (MEM_WORDS),
        .MEM_BASE       (MEM_BASE)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req),
        .dbg_req_i (dbg_req),
        .gnt_o     (gnt),
        .r_valid_o (r_valid),
        .err_o     (err),
        .r_rdata_o (rdata)
    );

    dbg_bridge_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .gnt_i         (gnt),
        .r_valid_i     (r_valid),
        .err_i         (err),
        .rdata_i       (rdata),
        .error_count_o (check_errors),
        .pending_o     (pending)
    );

    function automatic string to_text(input logic [8*16-1:0] raw);
        string s;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            if (raw[8*i +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, raw[8*i +: 8]);
            end
        end
        return s;
    endfunction

    // ============================================================
    // Stimulus file
    // ============================================================
    task automatic load_stimulus();
        int              fd;
        int              n;
        int              gap;
        int              exp_err;
        string           line;
        logic [8*16-1:0] name;
        logic [7:0]      op;
        logic [31:0]     addr, wdata, exp_rdata;
        logic [3:0]      be;
        stim_t           s;
        fd = $fopen("test/dbg_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/dbg_stim.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %d %h %d", name, op, addr, wdata,
                                be, gap, exp_rdata, exp_err);
                    if (n == 8) begin
                        s.name      = name;
                        s.is_write  = (op == "W");
                        s.addr      = addr;
                        s.wdata     = wdata;
                        s.be        = be;
                        s.gap       = 8'(gap);
                        s.exp_rdata = exp_rdata;
                        s.exp_err   = (exp_err != 0);
                        stim_q.push_back(s);
                    end
                end
            end
            $fclose(fd);
            load_ok = (stim_q.size() > 0);
            if (!load_ok) begin
                $display("The stimulus file holds no requests");
            end
        end
    endtask

    task automatic run_request(input stim_t s);
        // A zero gap keeps req_i high straight after the previous grant
        repeat (s.gap) begin
            req = 1'b0;
            @(negedge clk);
        end
        req           = 1'b1;
        dbg_req.addr  = s.addr;
        dbg_req.we    = s.is_write;
        dbg_req.wdata = s.wdata;
        dbg_req.be    = s.be;
        u_checker.push_expected(to_text(s.name), !s.is_write, s.exp_rdata, s.exp_err);
        @(negedge clk);
        while (gnt !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    initial begin
        req     = 1'b0;
        dbg_req = '0;
        load_stimulus();
        watchdog_cycles = stim_q.size() * (TIMEOUT_CYCLES + 8) + RESET_CYCLES + 4;
        loaded = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        foreach (stim_q[i]) begin
            run_request(stim_q[i]);
        end
        req = 1'b0;
        repeat (4) @(negedge clk);
        total_errors = check_errors + dut.u_fsm.u_assert.fail_count + (load_ok ? 0 : 1);
        $display("Summary: %0d requests, %0d errors, %0d grants missing",
                 stim_q.size(), total_errors, pending);
        if (total_errors == 0 && pending == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the request count
    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: requests still open after %0d cycles", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

/* test/dbg_stim.txt */
# name op addr wdata be gap exp_rdata exp_err
# op W or R, gap = idle cycles before the request (0 keeps req_i high), values in hex
full_wr0  W 00001000 11223344 F 1 00000000 0
full_wr1  W 000010FC CAFEBABE F 1 00000000 0
full_rd0  R 00001000 00000000 0 1 11223344 0
full_rd1  R 000010FC 00000000 0 1 CAFEBABE 0
part_wr0  W 00001000 000000EE 1 1 00000000 0
part_wr1  W 00001000 99887766 C 1 00000000 0
part_rd   R 00001000 00000000 0 1 998833EE 0
noop_wr   W 00001000 FFFFFFFF 0 1 00000000 0
noop_rd   R 00001000 00000000 0 1 998833EE 0
unal_wr0  W 00001013 87654321 F 1 00000000 0
unal_wr1  W 00001015 0000C0DE 3 1 00000000 0
unal_rd0  R 00001010 00000000 0 1 87654321 0
unal_rd1  R 00001017 00000000 0 1 0000C0DE 0
oow_rd0   R 00002000 00000000 0 1 00000000 1
oow_wr    W 00000FFC 12345678 F 1 00000000 1
oow_rd1   R 00001100 00000000 0 1 00000000 1
after_rd  R 000010FC 00000000 0 1 CAFEBABE 0
b2b_wr    W 00001020 01020304 F 0 00000000 0
b2b_rd0   R 00001020 00000000 0 0 01020304 0
b2b_noop  W 00001020 FFFFFFFF 0 0 00000000 0
b2b_oow   R 00003000 00000000 0 0 00000000 1
b2b_rd1   R 00001020 00000000 0 0 01020304 0

/* test/tb_clkgen.sv */
// Testbench clock and reset
// Free running clock and a synchronous active low reset that is
// released on a falling edge after RESET_CYCLES rising edges

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule
